// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_redmule_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST RESULT: PASS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+.
redmule_mem_pkg.sv
redmule_pkg.sv
redmule_ctrl.sv
redmule_scheduler.sv
redmule_source.sv
redmule_sink.sv
redmule_tcdm_arbiter.sv
redmule_engine.sv
redmule_top.sv
tb_redmule_asserts.sv
tb_redmule_top.sv

// File: redmule_ctrl.sv
/* Peripheral register file of the accelerator. Holds the matrix pointers,
   starts a job on a trigger write and raises busy and end-of-job events. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_ctrl (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  redmule_mem_pkg::periph_req_t periph_req_i,
  output redmule_mem_pkg::periph_rsp_t periph_rsp_o,
  input  logic                         job_done_i,
  output logic                         start_o,
  output redmule_pkg::job_t            job_o,
  output logic                         busy_o,
  output logic [`REDMULE_N_CORES-1:0]  evt_o
);

  logic [7:0]                  offset;
  logic                        wr_en;
  logic [31:0]                 rdata;
  logic [31:0]                 r_data_q;
  logic                        r_valid_q;
  logic                        busy_q;
  logic                        start_q;
  logic [`REDMULE_N_CORES-1:0] evt_q;
  redmule_pkg::job_t           job_q;

  assign offset = periph_req_i.addr[7:0];
  // Register writes are only accepted while idle
  assign wr_en  = periph_req_i.req & periph_req_i.we & ~busy_q;

  always_comb begin
    case (offset)
      `REDMULE_REG_X_PTR:  rdata = job_q.x_ptr;
      `REDMULE_REG_W_PTR:  rdata = job_q.w_ptr;
      `REDMULE_REG_Y_PTR:  rdata = job_q.y_ptr;
      `REDMULE_REG_Z_PTR:  rdata = job_q.z_ptr;
      `REDMULE_REG_STATUS: rdata = {31'b0, busy_q};
      default:             rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      job_q     <= '0;
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      evt_q     <= '0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= periph_req_i.req & ~periph_req_i.we;
      start_q   <= wr_en && (offset == `REDMULE_REG_TRIGGER);
      evt_q     <= {`REDMULE_N_CORES{job_done_i & busy_q}};
      if (wr_en && offset == `REDMULE_REG_TRIGGER) begin
        busy_q <= 1'b1;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
      end
      if (wr_en) begin
        case (offset)
          `REDMULE_REG_X_PTR: job_q.x_ptr <= periph_req_i.wdata;
          `REDMULE_REG_W_PTR: job_q.w_ptr <= periph_req_i.wdata;
          `REDMULE_REG_Y_PTR: job_q.y_ptr <= periph_req_i.wdata;
          `REDMULE_REG_Z_PTR: job_q.z_ptr <= periph_req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    r_data_q <= rdata;
  end

  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.r_data  = r_data_q;

  assign start_o = start_q;
  assign job_o   = job_q;
  assign busy_o  = busy_q;
  assign evt_o   = evt_q;

endmodule
`default_nettype wire

// File: redmule_defs.svh
/* Matrix sizes, bus widths and register offsets of the accelerator.
   Included by both packages and by every RTL file that needs a size. */
`ifndef REDMULE_DEFS_SVH
`define REDMULE_DEFS_SVH

// Element and bus widths
`define REDMULE_DATA_W     16
`define REDMULE_ADDR_W     32
`define REDMULE_ELEM_BYTES 2

// Z[M][K] = X[M][N] * W[N][K] + Y[M][K]
`define REDMULE_M 4
`define REDMULE_N 4
`define REDMULE_K 4

`define REDMULE_N_CORES 2

// Peripheral register map, byte offsets
`define REDMULE_REG_X_PTR   8'h00
`define REDMULE_REG_W_PTR   8'h04
`define REDMULE_REG_Y_PTR   8'h08
`define REDMULE_REG_Z_PTR   8'h0C
`define REDMULE_REG_TRIGGER 8'h10
`define REDMULE_REG_STATUS  8'h14

`endif

// File: redmule_engine.sv
/* One-row MAC engine. Buffers W, one X row and one Y row from the source,
   then computes a Z row in N steps with K lanes working in parallel. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_engine (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  redmule_pkg::load_beat_t beat_i,
  input  logic                    compute_i,
  output logic                    done_o,
  output redmule_pkg::z_row_t     z_row_o
);

  localparam int unsigned STEP_W = $clog2(`REDMULE_N);
  localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`REDMULE_N - 1);

  // W kept row-major, so element (n, k) sits at n*K + k
  redmule_pkg::elem_t [`REDMULE_N*`REDMULE_K-1:0] w_q;
  redmule_pkg::elem_t [`REDMULE_N-1:0]            x_q;
  redmule_pkg::z_row_t                            y_q;
  redmule_pkg::z_row_t                            acc_q;
  logic [STEP_W-1:0]                              step_q;
  logic                                           run_q;
  logic                                           done_q;

  always_ff @(posedge clk_i) begin
    if (beat_i.valid) begin
      case (beat_i.target)
        redmule_pkg::TGT_W: w_q[beat_i.idx] <= beat_i.data;
        redmule_pkg::TGT_X: x_q[beat_i.idx] <= beat_i.data;
        redmule_pkg::TGT_Y: y_q[beat_i.idx] <= beat_i.data;
        default: ;
      endcase
    end
  end

  // Accumulators start from the Y bias, products wrap to 16 bits
  always_ff @(posedge clk_i) begin
    if (compute_i) begin
      acc_q <= y_q;
    end else if (run_q) begin
      for (int k = 0; k < `REDMULE_K; k++) begin
        acc_q[k] <= acc_q[k] + x_q[step_q] * w_q[step_q * `REDMULE_K + k];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      step_q <= '0;
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= run_q && (step_q == STEP_LAST);
      if (compute_i) begin
        run_q  <= 1'b1;
        step_q <= '0;
      end else if (run_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == STEP_LAST) run_q <= 1'b0;
      end
    end
  end

  assign done_o  = done_q;
  assign z_row_o = acc_q;

endmodule
`default_nettype wire

// File: redmule_mem_pkg.sv
/* Bus-side types: the TCDM master port and the peripheral register port */
`default_nettype none
`include "redmule_defs.svh"

package redmule_mem_pkg;

  localparam int unsigned CORE_ID_W = $clog2(`REDMULE_N_CORES);

  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`REDMULE_ADDR_W-1:0] addr;
    logic [`REDMULE_DATA_W-1:0] wdata;
  } tcdm_req_t;

  // Read data comes back one cycle after the grant
  typedef struct packed {
    logic                       gnt;
    logic                       r_valid;
    logic [`REDMULE_DATA_W-1:0] r_data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`REDMULE_ADDR_W-1:0] addr;
    logic [31:0]                wdata;
    logic [CORE_ID_W-1:0]       id;
  } periph_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_data;
  } periph_rsp_t;

endpackage
`default_nettype wire

// File: redmule_pkg.sv
/* Compute-side types shared by the scheduler, streamer peers and engine */
`default_nettype none
`include "redmule_defs.svh"

package redmule_pkg;

  // Longest load run is the whole W matrix
  localparam int unsigned CNT_W = $clog2(`REDMULE_N * `REDMULE_K + 1);
  localparam int unsigned IDX_W = $clog2(`REDMULE_N * `REDMULE_K);

  typedef logic [`REDMULE_DATA_W-1:0] elem_t;
  typedef logic [CNT_W-1:0]           cnt_t;
  typedef logic [IDX_W-1:0]           idx_t;

  typedef struct packed {
    logic [`REDMULE_ADDR_W-1:0] x_ptr;
    logic [`REDMULE_ADDR_W-1:0] w_ptr;
    logic [`REDMULE_ADDR_W-1:0] y_ptr;
    logic [`REDMULE_ADDR_W-1:0] z_ptr;
  } job_t;

  typedef enum logic [1:0] {
    TGT_W = 2'd0,
    TGT_X = 2'd1,
    TGT_Y = 2'd2
  } target_e;

  typedef struct packed {
    logic                       valid;
    logic [`REDMULE_ADDR_W-1:0] base;
    cnt_t                       count;
    target_e                    target;
  } load_cmd_t;

  typedef struct packed {
    logic    valid;
    target_e target;
    idx_t    idx;
    elem_t   data;
  } load_beat_t;

  typedef elem_t [`REDMULE_K-1:0] z_row_t;

  typedef struct packed {
    logic                       valid;
    logic [`REDMULE_ADDR_W-1:0] base;
    z_row_t                     row;
  } store_cmd_t;

endpackage
`default_nettype wire

// File: redmule_scheduler.sv
/* Job sequencer. Loads W once, then per row loads X and Y, runs the
   engine and hands the Z row to the sink while the next row loads. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_scheduler (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    start_i,
  input  redmule_pkg::job_t       job_i,
  output redmule_pkg::load_cmd_t  load_cmd_o,
  input  logic                    load_done_i,
  output logic                    compute_o,
  input  logic                    engine_done_i,
  input  redmule_pkg::z_row_t     z_row_i,
  output redmule_pkg::store_cmd_t store_cmd_o,
  input  logic                    sink_busy_i,
  output logic                    job_done_o
);

  localparam int unsigned ROW_W = $clog2(`REDMULE_M);
  localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`REDMULE_M - 1);

  typedef enum logic [2:0] {
    IDLE, LOAD_W, LOAD_X, LOAD_Y, COMPUTE, STORE, FINISH
  } state_e;

  state_e                     state_q;
  logic [ROW_W-1:0]           row_q;
  logic                       issued_q;
  logic [`REDMULE_ADDR_W-1:0] row_off;

  // Byte offset of the current row in the K-wide Y and Z matrices
  assign row_off = `REDMULE_ADDR_W'(row_q) * (`REDMULE_K * `REDMULE_ELEM_BYTES);

  always_comb begin
    load_cmd_o       = '0;
    load_cmd_o.valid = ~issued_q & (state_q inside {LOAD_W, LOAD_X, LOAD_Y});
    case (state_q)
      LOAD_W: begin
        load_cmd_o.base   = job_i.w_ptr;
        load_cmd_o.count  = redmule_pkg::cnt_t'(`REDMULE_N * `REDMULE_K);
        load_cmd_o.target = redmule_pkg::TGT_W;
      end
      LOAD_X: begin
        load_cmd_o.base   = job_i.x_ptr
                          + `REDMULE_ADDR_W'(row_q) * (`REDMULE_N * `REDMULE_ELEM_BYTES);
        load_cmd_o.count  = redmule_pkg::cnt_t'(`REDMULE_N);
        load_cmd_o.target = redmule_pkg::TGT_X;
      end
      default: begin
        load_cmd_o.base   = job_i.y_ptr + row_off;
        load_cmd_o.count  = redmule_pkg::cnt_t'(`REDMULE_K);
        load_cmd_o.target = redmule_pkg::TGT_Y;
      end
    endcase
  end

  assign compute_o         = (state_q == COMPUTE) & ~issued_q;
  assign store_cmd_o.valid = (state_q == STORE) & ~sink_busy_i;
  assign store_cmd_o.base  = job_i.z_ptr + row_off;
  assign store_cmd_o.row   = z_row_i;
  assign job_done_o        = (state_q == FINISH) & ~sink_busy_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      row_q    <= '0;
      issued_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= LOAD_W;
            row_q   <= '0;
          end
        end
        LOAD_W, LOAD_X, LOAD_Y: begin
          issued_q <= ~load_done_i;
          if (load_done_i) begin
            state_q <= (state_q == LOAD_W) ? LOAD_X :
                       (state_q == LOAD_X) ? LOAD_Y : COMPUTE;
          end
        end
        COMPUTE: begin
          issued_q <= ~engine_done_i;
          if (engine_done_i) state_q <= STORE;
        end
        STORE: begin
          // Next row starts loading while the sink drains this one
          if (!sink_busy_i) begin
            if (row_q == ROW_LAST) begin
              state_q <= FINISH;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= LOAD_X;
            end
          end
        end
        default: begin
          if (!sink_busy_i) state_q <= IDLE;
        end
      endcase
    end
  end

endmodule
`default_nettype wire

// File: redmule_sink.sv
/* Store peer of the streamer. Holds one Z row and writes its K words
   to consecutive addresses, one per grant. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_sink (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  redmule_pkg::store_cmd_t    store_cmd_i,
  output redmule_mem_pkg::tcdm_req_t tcdm_req_o,
  input  logic                       gnt_i,
  output logic                       sink_busy_o
);

  localparam int unsigned COL_W = $clog2(`REDMULE_K);
  localparam logic [COL_W-1:0] COL_LAST = COL_W'(`REDMULE_K - 1);

  logic                       active_q;
  logic [COL_W-1:0]           col_q;
  logic [`REDMULE_ADDR_W-1:0] addr_q;
  redmule_pkg::z_row_t        row_q;
  logic                       last;

  assign last = (col_q == COL_LAST);

  assign tcdm_req_o.req   = active_q;
  assign tcdm_req_o.we    = 1'b1;
  assign tcdm_req_o.addr  = addr_q;
  assign tcdm_req_o.wdata = row_q[col_q];

  // Free already in the cycle the last word is granted
  assign sink_busy_o = active_q & ~(gnt_i & last);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      col_q    <= '0;
    end else if (store_cmd_i.valid) begin
      active_q <= 1'b1;
      col_q    <= '0;
    end else if (active_q && gnt_i) begin
      col_q <= col_q + 1'b1;
      if (last) active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_cmd_i.valid) begin
      addr_q <= store_cmd_i.base;
      row_q  <= store_cmd_i.row;
    end else if (active_q && gnt_i) begin
      addr_q <= addr_q + `REDMULE_ELEM_BYTES;
    end
  end

endmodule
`default_nettype wire

// File: redmule_source.sv
/* Load peer of the streamer. Reads a run of consecutive words and tags
   every returned word with its target buffer and position in the run. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_source (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  redmule_pkg::load_cmd_t     load_cmd_i,
  output redmule_mem_pkg::tcdm_req_t tcdm_req_o,
  input  logic                       gnt_i,
  input  redmule_mem_pkg::tcdm_rsp_t tcdm_rsp_i,
  output redmule_pkg::load_beat_t    beat_o,
  output logic                       load_done_o
);

  redmule_pkg::cnt_t          req_left_q;
  redmule_pkg::cnt_t          rsp_left_q;
  redmule_pkg::idx_t          idx_q;
  redmule_pkg::target_e       target_q;
  logic [`REDMULE_ADDR_W-1:0] addr_q;
  logic                       done_q;
  logic                       issue;

  assign issue = tcdm_req_o.req & gnt_i;

  assign tcdm_req_o.req   = (req_left_q != '0);
  assign tcdm_req_o.we    = 1'b0;
  assign tcdm_req_o.addr  = addr_q;
  assign tcdm_req_o.wdata = '0;

  assign beat_o.valid  = tcdm_rsp_i.r_valid;
  assign beat_o.target = target_q;
  assign beat_o.idx    = idx_q;
  assign beat_o.data   = tcdm_rsp_i.r_data;
  assign load_done_o   = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_left_q <= '0;
      rsp_left_q <= '0;
      idx_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= tcdm_rsp_i.r_valid && (rsp_left_q == 1);
      if (load_cmd_i.valid) begin
        req_left_q <= load_cmd_i.count;
        rsp_left_q <= load_cmd_i.count;
        idx_q      <= '0;
      end else begin
        if (issue) req_left_q <= req_left_q - 1'b1;
        // Responses come back in order, so a running index is enough
        if (tcdm_rsp_i.r_valid) begin
          rsp_left_q <= rsp_left_q - 1'b1;
          idx_q      <= idx_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_cmd_i.valid) begin
      addr_q   <= load_cmd_i.base;
      target_q <= load_cmd_i.target;
    end else if (issue) begin
      addr_q <= addr_q + `REDMULE_ELEM_BYTES;
    end
  end

endmodule
`default_nettype wire

// File: redmule_tcdm_arbiter.sv
/* Round-robin arbiter putting the source and the sink on one TCDM port.
   Read responses always belong to the source. */
`default_nettype none

module redmule_tcdm_arbiter (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  redmule_mem_pkg::tcdm_req_t src_req_i,
  input  redmule_mem_pkg::tcdm_req_t snk_req_i,
  output logic                       src_gnt_o,
  output logic                       snk_gnt_o,
  output redmule_mem_pkg::tcdm_req_t tcdm_req_o,
  input  redmule_mem_pkg::tcdm_rsp_t tcdm_rsp_i,
  output redmule_mem_pkg::tcdm_rsp_t src_rsp_o
);

  logic prio_snk_q;
  logic lock_q;
  logic sel_q;
  logic sel_snk;
  logic both;

  assign both = src_req_i.req & snk_req_i.req;

  // A stalled request keeps the port so address and data stay stable
  assign sel_snk = lock_q ? sel_q
                          : snk_req_i.req & (~src_req_i.req | prio_snk_q);

  assign tcdm_req_o = sel_snk ? snk_req_i : src_req_i;
  assign src_gnt_o  = ~sel_snk & src_req_i.req & tcdm_rsp_i.gnt;
  assign snk_gnt_o  = sel_snk & snk_req_i.req & tcdm_rsp_i.gnt;

  assign src_rsp_o.gnt     = src_gnt_o;
  assign src_rsp_o.r_valid = tcdm_rsp_i.r_valid;
  assign src_rsp_o.r_data  = tcdm_rsp_i.r_data;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_snk_q <= 1'b0;
      lock_q     <= 1'b0;
      sel_q      <= 1'b0;
    end else begin
      lock_q <= tcdm_req_o.req & ~tcdm_rsp_i.gnt;
      sel_q  <= sel_snk;
      if (both && tcdm_rsp_i.gnt) prio_snk_q <= ~sel_snk;
    end
  end

endmodule
`default_nettype wire

// File: redmule_top.sv
/* Top level of the matrix-multiply accelerator. Register port for the
   cores, one TCDM master port for the streamer. */
`default_nettype none
`include "redmule_defs.svh"

module redmule_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  redmule_mem_pkg::periph_req_t periph_req_i,
  output redmule_mem_pkg::periph_rsp_t periph_rsp_o,
  output redmule_mem_pkg::tcdm_req_t   tcdm_req_o,
  input  redmule_mem_pkg::tcdm_rsp_t   tcdm_rsp_i,
  output logic                         busy_o,
  output logic [`REDMULE_N_CORES-1:0]  evt_o
);

  logic                       start;
  logic                       job_done;
  redmule_pkg::job_t          job;
  redmule_pkg::load_cmd_t     load_cmd;
  logic                       load_done;
  redmule_pkg::load_beat_t    beat;
  logic                       compute;
  logic                       engine_done;
  redmule_pkg::z_row_t        z_row;
  redmule_pkg::store_cmd_t    store_cmd;
  logic                       sink_busy;
  redmule_mem_pkg::tcdm_req_t src_req;
  redmule_mem_pkg::tcdm_req_t snk_req;
  redmule_mem_pkg::tcdm_rsp_t src_rsp;
  logic                       src_gnt;
  logic                       snk_gnt;

  redmule_ctrl i_control (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .job_done_i   ( job_done     ),
    .start_o      ( start        ),
    .job_o        ( job          ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        )
  );

  redmule_scheduler i_scheduler (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .start_i       ( start       ),
    .job_i         ( job         ),
    .load_cmd_o    ( load_cmd    ),
    .load_done_i   ( load_done   ),
    .compute_o     ( compute     ),
    .engine_done_i ( engine_done ),
    .z_row_i       ( z_row       ),
    .store_cmd_o   ( store_cmd   ),
    .sink_busy_i   ( sink_busy   ),
    .job_done_o    ( job_done    )
  );

  redmule_source i_source (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .load_cmd_i  ( load_cmd  ),
    .tcdm_req_o  ( src_req   ),
    .gnt_i       ( src_gnt   ),
    .tcdm_rsp_i  ( src_rsp   ),
    .beat_o      ( beat      ),
    .load_done_o ( load_done )
  );

  redmule_sink i_sink (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .store_cmd_i ( store_cmd ),
    .tcdm_req_o  ( snk_req   ),
    .gnt_i       ( snk_gnt   ),
    .sink_busy_o ( sink_busy )
  );

  redmule_tcdm_arbiter i_arbiter (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .src_req_i  ( src_req    ),
    .snk_req_i  ( snk_req    ),
    .src_gnt_o  ( src_gnt    ),
    .snk_gnt_o  ( snk_gnt    ),
    .tcdm_req_o ( tcdm_req_o ),
    .tcdm_rsp_i ( tcdm_rsp_i ),
    .src_rsp_o  ( src_rsp    )
  );

  redmule_engine i_engine (
    .clk_i     ( clk_i       ),
    .arst_n_i  ( arst_n_i    ),
    .beat_i    ( beat        ),
    .compute_i ( compute     ),
    .done_o    ( engine_done ),
    .z_row_o   ( z_row       )
  );

endmodule
`default_nettype wire

// File: tb_redmule_asserts.sv
/* Concurrent checks on the TCDM port, the end-of-job event and the
   arbiter grants, bound into the accelerator top level */
`default_nettype none
`include "redmule_defs.svh"

module tb_redmule_asserts (
  input logic                        clk_i,
  input logic                        arst_n_i,
  input redmule_mem_pkg::tcdm_req_t  tcdm_req_i,
  input redmule_mem_pkg::tcdm_rsp_t  tcdm_rsp_i,
  input logic                        busy_i,
  input logic [`REDMULE_N_CORES-1:0] evt_i,
  input logic                        src_gnt_i,
  input logic                        snk_gnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned n_fail = 0;

  // A stalled request keeps its address and data until granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tcdm_req_i.req && !tcdm_rsp_i.gnt |=> tcdm_req_i.req && $stable(tcdm_req_i.we)
      && $stable(tcdm_req_i.addr) && $stable(tcdm_req_i.wdata))
  else begin
    n_fail++;
    $error("TCDM request changed while it was stalled");
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_i != '0 |-> $fell(busy_i))
  else begin
    n_fail++;
    $error("evt_o high outside the cycle in which busy_o falls");
  end

  // A port grant reaches only the peer driving the port
  // The sink only writes and the source only reads
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(src_gnt_i && snk_gnt_i)
      && (src_gnt_i == (tcdm_req_i.req && tcdm_rsp_i.gnt && !tcdm_req_i.we))
      && (snk_gnt_i == (tcdm_req_i.req && tcdm_rsp_i.gnt && tcdm_req_i.we)))
  else begin
    n_fail++;
    $error("source and sink grants do not match the granted TCDM request");
  end

endmodule

bind redmule_top tb_redmule_asserts i_asserts (
  .clk_i      ( clk_i      ),
  .arst_n_i   ( arst_n_i   ),
  .tcdm_req_i ( tcdm_req_o ),
  .tcdm_rsp_i ( tcdm_rsp_i ),
  .busy_i     ( busy_o     ),
  .evt_i      ( evt_o      ),
  .src_gnt_i  ( src_gnt    ),
  .snk_gnt_i  ( snk_gnt    )
);
`default_nettype wire

// File: tb_redmule_top.sv
/* Self-checking testbench of the accelerator top level. Random jobs run
   against a TCDM memory model and a reference model of Z = X*W + Y. */
`default_nettype none
`include "redmule_defs.svh"

module tb_redmule_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned M = `REDMULE_M;
  localparam int unsigned N = `REDMULE_N;
  localparam int unsigned K = `REDMULE_K;
  localparam int unsigned N_JOBS = 5;
  localparam int unsigned WATCHDOG_CYCLES = N_JOBS * (M * (N + 2 * K) + N * K) * 20 + 1000;
  localparam logic [31:0] SEED = 32'h4689f548;

  logic                         clk_i = 1'b0;
  logic                         arst_n_i;
  redmule_mem_pkg::periph_req_t periph_req_i;
  redmule_mem_pkg::periph_rsp_t periph_rsp_o;
  redmule_mem_pkg::tcdm_req_t   tcdm_req_o;
  redmule_mem_pkg::tcdm_rsp_t   tcdm_rsp_i = '0;
  logic                         busy_o;
  logic [`REDMULE_N_CORES-1:0]  evt_o;

  integer             data_seed = SEED;
  integer             gnt_seed = SEED;
  logic               random_gnt;
  logic               read_pending = 1'b0;
  redmule_pkg::elem_t read_data = '0;
  // Input matrices, words written by the DUT, expected Z words
  redmule_pkg::elem_t init_mem [logic [31:0]];
  redmule_pkg::elem_t dut_mem [logic [31:0]];
  redmule_pkg::elem_t z_ref [logic [31:0]];
  int unsigned        n_checks = 0;
  int unsigned        n_errors = 0;
  int unsigned        n_evt_cycles = 0;
  int unsigned        n_busy_rises = 0;
  logic               busy_prev = 1'b0;

  redmule_top UUT (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .tcdm_req_o   ( tcdm_req_o   ),
    .tcdm_rsp_i   ( tcdm_rsp_i   ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        )
  );

  always #2 clk_i = ~clk_i;

  function automatic redmule_pkg::elem_t fill_word(input logic [31:0] addr);
    return addr[15:0] ^ addr[31:16] ^ 16'h5a3c;
  endfunction

  function automatic redmule_pkg::elem_t mem_word(input logic [31:0] addr);
    if (dut_mem.exists(addr)) return dut_mem[addr];
    if (init_mem.exists(addr)) return init_mem[addr];
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] elem_addr(input logic [31:0] base, input int unsigned idx);
    return base + idx * `REDMULE_ELEM_BYTES;
  endfunction

  // TCDM memory, reads answer one cycle after the grant
  always @(negedge clk_i) begin
    tcdm_rsp_i.r_valid = read_pending;
    tcdm_rsp_i.r_data  = read_data;
    read_pending       = 1'b0;
    tcdm_rsp_i.gnt     = random_gnt ? (($random(gnt_seed) & 3) != 0) : 1'b1;
    if (arst_n_i && tcdm_req_o.req && tcdm_rsp_i.gnt) begin
      if (tcdm_req_o.we) begin
        dut_mem[tcdm_req_o.addr] = tcdm_req_o.wdata;
      end else begin
        read_pending = 1'b1;
        read_data    = mem_word(tcdm_req_o.addr);
      end
    end
  end

  always @(negedge clk_i) begin
    if (evt_o != '0) n_evt_cycles++;
    if (busy_o && !busy_prev) n_busy_rises++;
    busy_prev = busy_o;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_elem(input redmule_pkg::elem_t got, input redmule_pkg::elem_t exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_evt(input logic [`REDMULE_N_CORES-1:0] got,
                           input logic [`REDMULE_N_CORES-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned c0, input int unsigned e0);
    $display("test %-20s %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
  endtask

  task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
    periph_req_i.req   = 1'b1;
    periph_req_i.we    = 1'b1;
    periph_req_i.addr  = 32'(offset);
    periph_req_i.wdata = data;
    @(negedge clk_i);
    check_bit(periph_rsp_o.gnt, 1'b1, "register write grant");
    periph_req_i = '0;
  endtask

  // Read data is valid one cycle after the grant
  task automatic read_reg(input logic [7:0] offset, output logic [31:0] data);
    periph_req_i.req  = 1'b1;
    periph_req_i.we   = 1'b0;
    periph_req_i.addr = 32'(offset);
    @(negedge clk_i);
    check_bit(periph_rsp_o.gnt, 1'b1, "register read grant");
    periph_req_i = '0;
    check_bit(periph_rsp_o.r_valid, 1'b1, "register read valid");
    data = periph_rsp_o.r_data;
  endtask

  task automatic put_input(input logic [31:0] addr);
    init_mem[addr] = redmule_pkg::elem_t'($random(data_seed));
  endtask

  task automatic prepare_job(input int unsigned j, output redmule_pkg::job_t job);
    logic [31:0]        base;
    redmule_pkg::elem_t acc;
    base      = 32'h0001_0000 + j * 32'h0000_1000;
    job.x_ptr = base;
    job.w_ptr = base + 32'h100;
    job.y_ptr = base + 32'h200;
    job.z_ptr = base + 32'h300;
    for (int unsigned i = 0; i < M * N; i++) put_input(elem_addr(job.x_ptr, i));
    for (int unsigned i = 0; i < N * K; i++) put_input(elem_addr(job.w_ptr, i));
    for (int unsigned i = 0; i < M * K; i++) put_input(elem_addr(job.y_ptr, i));
    // Reference model, every sum wraps to the element width
    for (int unsigned m = 0; m < M; m++) begin
      for (int unsigned k = 0; k < K; k++) begin
        acc = init_mem[elem_addr(job.y_ptr, m * K + k)];
        for (int unsigned n = 0; n < N; n++) begin
          acc = acc + init_mem[elem_addr(job.x_ptr, m * N + n)]
                    * init_mem[elem_addr(job.w_ptr, n * K + k)];
        end
        z_ref[elem_addr(job.z_ptr, m * K + k)] = acc;
      end
    end
  endtask

  task automatic wait_job_end();
    @(negedge clk_i);
    while (busy_o && evt_o == '0) @(negedge clk_i);
    check_bit(busy_o, 1'b0, "busy_o at end of job");
    check_evt(evt_o, '1, "evt_o at end of job");
    @(negedge clk_i);
    check_evt(evt_o, '0, "evt_o after end of job");
  endtask

  task automatic check_z(input redmule_pkg::job_t job);
    logic [31:0] addr;
    for (int unsigned m = 0; m < M; m++) begin
      for (int unsigned k = 0; k < K; k++) begin
        addr = elem_addr(job.z_ptr, m * K + k);
        check_elem(mem_word(addr), z_ref[addr], $sformatf("Z[%0d][%0d] at %h", m, k, addr));
      end
    end
  endtask

  // Every word the DUT wrote must be an expected Z word
  task automatic check_memory();
    redmule_pkg::elem_t exp;
    foreach (dut_mem[a]) begin
      exp = z_ref.exists(a) ? z_ref[a] : (init_mem.exists(a) ? init_mem[a] : fill_word(a));
      check_elem(dut_mem[a], exp, $sformatf("memory word at %h", a));
    end
  endtask

  task automatic run_job(input redmule_pkg::job_t job, input logic disturb);
    logic [31:0] rdata;
    write_reg(`REDMULE_REG_X_PTR, job.x_ptr);
    write_reg(`REDMULE_REG_W_PTR, job.w_ptr);
    write_reg(`REDMULE_REG_Y_PTR, job.y_ptr);
    write_reg(`REDMULE_REG_Z_PTR, job.z_ptr);
    write_reg(`REDMULE_REG_TRIGGER, 32'h1);
    check_bit(busy_o, 1'b1, "busy_o one cycle after trigger");
    read_reg(`REDMULE_REG_STATUS, rdata);
    check_reg(rdata, 32'h1, "status during job");
    if (disturb) begin
      // Both writes land while busy
      write_reg(`REDMULE_REG_TRIGGER, 32'h1);
      write_reg(`REDMULE_REG_X_PTR, 32'h0001_0000);
    end
    wait_job_end();
    check_z(job);
    if (disturb) begin
      read_reg(`REDMULE_REG_X_PTR, rdata);
      check_reg(rdata, job.x_ptr, "X pointer after job");
      repeat (40) @(negedge clk_i);
      check_bit(busy_o, 1'b0, "busy_o long after job");
    end
  endtask

  initial begin
    redmule_pkg::job_t job;
    logic [31:0]       ptr [4];
    logic [31:0]       rdata;
    int unsigned       c0;
    int unsigned       e0;
    arst_n_i     = 1'b0;
    periph_req_i = '0;
    random_gnt   = 1'b0;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    c0 = n_checks;
    e0 = n_errors;
    check_bit(busy_o, 1'b0, "busy_o after reset");
    check_evt(evt_o, '0, "evt_o after reset");
    check_bit(tcdm_req_o.req, 1'b0, "TCDM request after reset");
    read_reg(`REDMULE_REG_STATUS, rdata);
    check_reg(rdata, 32'h0, "status after reset");
    for (int r = 0; r < 4; r++) begin
      ptr[r] = $random(data_seed);
      write_reg(8'(4 * r), ptr[r]);
    end
    for (int r = 0; r < 4; r++) begin
      read_reg(8'(4 * r), rdata);
      check_reg(rdata, ptr[r], $sformatf("pointer register %0d", r));
    end
    report_test("register access", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    prepare_job(0, job);
    run_job(job, 1'b0);
    report_test("single job", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    // Takes effect after the memory model has sampled this edge
    random_gnt <= 1'b1;
    for (int unsigned j = 1; j <= 3; j++) begin
      prepare_job(j, job);
      run_job(job, 1'b0);
    end
    check_memory();
    report_test("back-to-back jobs", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    prepare_job(4, job);
    run_job(job, 1'b1);
    check_memory();
    report_test("writes while busy", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    check_reg(n_busy_rises, N_JOBS, "busy_o rising edges");
    check_reg(n_evt_cycles, N_JOBS, "evt_o pulse cycles");
    report_test("busy and events", c0, e0);

    $display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
             UUT.i_asserts.n_fail);
    if (n_errors == 0 && UUT.i_asserts.n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
`default_nettype wire
